// ==== flist.f ====
decode_pkg.sv
decode_cfg.sv
id0.sv
id1_ctrl_imm.sv
id1.sv
decode_top.sv
tb_clock.sv
tb_decode_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_decode_top -f flist.f
	./obj_dir/Vtb_decode_top | awk '{ print } /^Simulation PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== tb_decode_top.sv ====
// ################################################
// Decode front testbench with a queue model. Outputs
// sampled on the falling edge, the run stops at a cycle limit
// ################################################

module tb_decode_top;

  localparam int DriveDelay = 2;
  localparam int NumStrobes = 80;  // Upper bound over all tests
  localparam int CycleLimit = 8 + 2 * NumStrobes + 10 * 6;

  logic                   clk;
  logic                   rst_n;
  logic                   flush;
  logic                   fetch_valid;
  decode_pkg::fetch_pkt_t fetch;
  logic                   cfg_wr;
  decode_pkg::pred_mode_t cfg_wdata;
  decode_pkg::pred_mode_t cfg_rdata;
  logic                   exec_valid;
  decode_pkg::exec_pkt_t  exec;

  decode_pkg::exec_pkt_t  want_q[$];
  int                     issue_q[$];
  decode_pkg::pred_mode_t mode_model;
  decode_pkg::pc_t        pc_next;
  int                     cyc = 0;
  int                     errors = 0;
  int                     test_errors = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  string                  test_name;
  integer                 seed;

  tb_clock i_tb_clock (
    .clk  (clk),
    .rst_n(rst_n)
  );

  decode_top i_decode_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .fetch_valid(fetch_valid),
    .fetch      (fetch),
    .cfg_wr     (cfg_wr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .exec_valid (exec_valid),
    .exec       (exec)
  );

  always @(posedge clk) cyc <= cyc + 1;

  always @(posedge clk) begin
    if (cyc >= CycleLimit) begin
      $display("Timeout: run still going after %0d cycles", CycleLimit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("CHECK FAILED at time %0t: %s", $time, msg);
      errors = errors + 1;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #DriveDelay;
  endtask

  // Instruction encoders
  function automatic decode_pkg::instr_t r_type(input logic [6:0] f7,
      input decode_pkg::reg_addr_t rs2, input decode_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input decode_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, decode_pkg::op_op};
  endfunction

  function automatic decode_pkg::instr_t i_type(input logic [11:0] imm,
      input decode_pkg::reg_addr_t rs1, input logic [2:0] f3,
      input decode_pkg::reg_addr_t rd, input decode_pkg::opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic decode_pkg::instr_t s_type(input logic [11:0] imm,
      input decode_pkg::reg_addr_t rs2, input decode_pkg::reg_addr_t rs1,
      input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], decode_pkg::op_store};
  endfunction

  function automatic decode_pkg::instr_t b_type(input logic [12:0] off,
      input decode_pkg::reg_addr_t rs2, input decode_pkg::reg_addr_t rs1,
      input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], decode_pkg::op_branch};
  endfunction

  function automatic decode_pkg::instr_t u_type(input logic [19:0] imm,
      input decode_pkg::reg_addr_t rd, input decode_pkg::opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic decode_pkg::instr_t j_type(input logic [20:0] off,
      input decode_pkg::reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, decode_pkg::op_jal};
  endfunction

  function automatic decode_pkg::reg_addr_t rnd_reg();
    return 5'($random(seed));
  endfunction

  function automatic logic [11:0] rnd_imm12();
    return 12'($random(seed));
  endfunction

  function automatic decode_pkg::alu_op_t alu_code(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
      3'd1:    return decode_pkg::alu_sll;
      3'd2:    return decode_pkg::alu_slt;
      3'd3:    return decode_pkg::alu_sltu;
      3'd4:    return decode_pkg::alu_xor;
      3'd5:    return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'd6:    return decode_pkg::alu_or;
      default: return decode_pkg::alu_and;
    endcase
  endfunction

  // Reference model of both stages for one strobe
  function automatic decode_pkg::exec_pkt_t predict(input decode_pkg::instr_t instr,
      input decode_pkg::pc_t pc, input decode_pkg::pred_mode_t mode);
    decode_pkg::exec_pkt_t e;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [31:0]           imm_i;
    logic                  legal;
    logic                  writes;
    f3        = instr[14:12];
    f7        = instr[31:25];
    imm_i     = $signed(instr) >>> 20;
    e         = '0;
    e.pc      = pc;
    e.rd_addr = instr[11:7];
    e.comp    = (instr[1:0] != 2'b11);
    legal     = 1'b0;
    writes    = 1'b0;
    case (instr[6:0])
      decode_pkg::op_lui: begin
        legal     = 1'b1;
        writes    = 1'b1;
        e.alu     = 1'b1;
        e.use_imm = 1'b1;
        e.imm     = instr & 32'hffff_f000;
        e.alu_op  = decode_pkg::alu_pass_b;
      end
      decode_pkg::op_auipc: begin
        legal     = 1'b1;
        writes    = 1'b1;
        e.alu     = 1'b1;
        e.use_imm = 1'b1;
        e.use_pc  = 1'b1;
        e.imm     = instr & 32'hffff_f000;
        e.alu_op  = decode_pkg::alu_add;
      end
      decode_pkg::op_jal, decode_pkg::op_jalr: begin
        legal       = (instr[3] == 1'b1) || (f3 == 3'd0);  // jal has bit 3 set
        writes      = 1'b1;
        e.br        = 1'b1;
        e.br_ataken = 1'b1;
        e.use_imm   = 1'b1;
        e.use_pc    = instr[3];
        e.imm       = instr[3] ?
                      {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0} : imm_i;
        e.br_op     = decode_pkg::br_jump;
      end
      decode_pkg::op_branch: begin
        legal       = !(f3 inside {3'd2, 3'd3});
        e.br        = 1'b1;
        e.br_ataken = (mode == decode_pkg::pred_always) ||
                      (mode == decode_pkg::pred_backward && instr[31]);
        e.use_imm   = 1'b1;
        e.use_pc    = 1'b1;
        e.imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        e.br_op     = f3;
      end
      decode_pkg::op_load: begin
        legal     = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        writes    = 1'b1;
        e.lsu     = 1'b1;
        e.use_imm = 1'b1;
        e.imm     = imm_i;
        e.lsu_op  = f3;
      end
      decode_pkg::op_store: begin
        legal     = f3 inside {3'd0, 3'd1, 3'd2};
        e.lsu     = 1'b1;
        e.use_imm = 1'b1;
        e.imm     = {imm_i[31:5], instr[11:7]};
        e.lsu_op  = f3;
      end
      decode_pkg::op_op_imm: begin
        legal     = (f3 == 3'd1) ? (f7 == 7'h00) :
                    (f3 == 3'd5) ? (f7 inside {7'h00, 7'h20}) : 1'b1;
        writes    = 1'b1;
        e.alu     = 1'b1;
        e.use_imm = 1'b1;
        e.imm     = imm_i;
        e.alu_op  = alu_code(f3, f3 == 3'd5 && instr[30]);
      end
      decode_pkg::op_op: begin
        legal    = (f7 == 7'h00) || (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
        writes   = 1'b1;
        e.alu    = 1'b1;
        e.alu_op = alu_code(f3, instr[30]);
      end
      decode_pkg::op_misc_mem: legal = (f3 == 3'd0);
      default: legal = 1'b0;
    endcase
    e.illegal = !legal || e.comp;
    if (e.illegal) begin
      e.alu = 1'b0;
      e.lsu = 1'b0;
    end
    e.rd_en = writes && (e.rd_addr != 5'd0) && !e.illegal;
    return e;
  endfunction

  // Fields with a defined value for this instruction
  function automatic decode_pkg::exec_pkt_t care_mask(input decode_pkg::exec_pkt_t want);
    decode_pkg::exec_pkt_t m;
    m = '1;
    if (want.illegal) begin
      m.use_imm = 1'b0;
      m.use_pc  = 1'b0;
      m.imm     = '0;
      m.alu_op  = '0;
      m.lsu_op  = '0;
      m.br_op   = '0;
    end
    if (!want.use_imm) m.imm = '0;
    if (!want.alu) m.alu_op = '0;
    if (!want.lsu) m.lsu_op = '0;
    if (!want.br) m.br_op = '0;
    return m;
  endfunction

  task automatic check_exec();
    decode_pkg::exec_pkt_t want;
    decode_pkg::exec_pkt_t mask;
    int                    issued;
    assert (want_q.size() != 0) else begin
      $display("exec_valid high at %0t with no instruction in flight", $time);
      errors = errors + 1;
    end
    if (want_q.size() != 0) begin
      want   = want_q.pop_front();
      issued = issue_q.pop_front();
      mask   = care_mask(want);
      check(((exec ^ want) & mask) == '0,
            $sformatf("pc %h: exec %h, want %h", {want.pc, 1'b0}, exec, want));
      check(cyc == issued + 2, $sformatf("latency %0d cycles, want 2", cyc - issued));
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && exec_valid) check_exec();
  end

  task automatic issue(input decode_pkg::instr_t instr);
    fetch_valid = 1'b1;
    fetch.instr = instr;
    fetch.pc    = pc_next;
    want_q.push_back(predict(instr, pc_next, mode_model));
    issue_q.push_back(cyc);
    pc_next = pc_next + 31'd2;
    step();
    fetch_valid = 1'b0;
  endtask

  task automatic flush_with_strobe(input decode_pkg::instr_t instr);
    flush       = 1'b1;
    fetch_valid = 1'b1;
    fetch.instr = instr;
    fetch.pc    = pc_next;
    // Whatever reached id1 last cycle dies with the flush
    while (issue_q.size() != 0 && issue_q[$] >= cyc - 1) begin
      void'(issue_q.pop_back());
      void'(want_q.pop_back());
    end
    step();
    flush       = 1'b0;
    fetch_valid = 1'b0;
  endtask

  task automatic set_mode(input decode_pkg::pred_mode_t mode);
    cfg_wr    = 1'b1;
    cfg_wdata = mode;
    step();
    cfg_wr     = 1'b0;
    mode_model = mode;
    check(cfg_rdata == mode, $sformatf("cfg_rdata %0d, want %0d", cfg_rdata, mode));
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    while (want_q.size() != 0) step();
    repeat (3) step();  // Room for a stray exec_valid
    tests_run = tests_run + 1;
    if (errors != test_errors) begin
      tests_failed = tests_failed + 1;
      $display("test %s: failed with %0d errors", test_name, errors - test_errors);
    end else begin
      $display("test %s: passed", test_name);
    end
  endtask

  task automatic branch_round(input decode_pkg::pred_mode_t mode);
    logic [12:0] off;
    set_mode(mode);
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        off = f[0] ? 13'h1ff0 : 13'h0020;  // Odd codes jump back
        issue(b_type(off, rnd_reg(), rnd_reg(), 3'(f)));
      end
    end
    issue(j_type(21'h1ffff8, rnd_reg()));
    issue(i_type(rnd_imm12(), rnd_reg(), 3'd0, rnd_reg(), decode_pkg::op_jalr));
  endtask

  initial begin
    seed        = 32'h68ed;
    flush       = 1'b0;
    fetch_valid = 1'b0;
    fetch       = '0;
    cfg_wr      = 1'b0;
    cfg_wdata   = decode_pkg::pred_backward;
    mode_model  = decode_pkg::pred_backward;
    pc_next     = 31'h200;
    wait (rst_n);

    // Reset values, before the first edge after release
    begin_test("reset");
    check(exec_valid == 1'b0, "exec_valid set after reset");
    check({exec.rd_en, exec.alu, exec.lsu, exec.br, exec.illegal} == 5'b0,
          "control bits set after reset");
    check(cfg_rdata == decode_pkg::pred_backward, "cfg_rdata not backward after reset");
    end_test();

    begin_test("alu");
    for (int f = 0; f < 8; f++) begin
      issue(r_type(7'h00, rnd_reg(), rnd_reg(), 3'(f), rnd_reg()));
      if (f != 1 && f != 5) begin
        issue(i_type(rnd_imm12(), rnd_reg(), 3'(f), rnd_reg(), decode_pkg::op_op_imm));
      end
    end
    issue(r_type(7'h20, rnd_reg(), rnd_reg(), 3'd0, rnd_reg()));  // sub
    issue(r_type(7'h20, rnd_reg(), rnd_reg(), 3'd5, rnd_reg()));  // sra
    issue(i_type({7'h00, rnd_reg()}, rnd_reg(), 3'd1, rnd_reg(), decode_pkg::op_op_imm));
    issue(i_type({7'h00, rnd_reg()}, rnd_reg(), 3'd5, rnd_reg(), decode_pkg::op_op_imm));
    issue(i_type({7'h20, rnd_reg()}, rnd_reg(), 3'd5, rnd_reg(), decode_pkg::op_op_imm));
    issue(u_type(20'($random(seed)), rnd_reg(), decode_pkg::op_lui));
    issue(u_type(20'($random(seed)), rnd_reg(), decode_pkg::op_auipc));
    issue(r_type(7'h00, rnd_reg(), rnd_reg(), 3'd0, 5'd0));  // Writes to x0
    issue(u_type(20'($random(seed)), 5'd0, decode_pkg::op_lui));
    end_test();

    begin_test("lsu");
    for (int f = 0; f < 6; f++) begin
      if (f != 3) begin
        issue(i_type(rnd_imm12(), rnd_reg(), 3'(f), rnd_reg(), decode_pkg::op_load));
      end
      if (f < 3) begin
        issue(s_type(rnd_imm12(), rnd_reg(), rnd_reg(), 3'(f)));
      end
    end
    issue(i_type(rnd_imm12(), rnd_reg(), 3'd2, 5'd0, decode_pkg::op_load));
    end_test();

    begin_test("predict");
    branch_round(decode_pkg::pred_never);
    branch_round(decode_pkg::pred_backward);
    branch_round(decode_pkg::pred_always);
    end_test();

    begin_test("flush");
    repeat (2) begin
      issue(i_type(rnd_imm12(), rnd_reg(), 3'd0, rnd_reg(), decode_pkg::op_op_imm));
      issue(i_type(rnd_imm12(), rnd_reg(), 3'd0, rnd_reg(), decode_pkg::op_op_imm));
      flush_with_strobe(i_type(rnd_imm12(), rnd_reg(), 3'd0, rnd_reg(),
                               decode_pkg::op_op_imm));
      step();
    end
    end_test();

    begin_test("illegal");
    issue(32'h0000_4501);  // c.li
    issue(32'h0000_8082);  // c.jr
    issue(32'h0000_4108);  // c.lw
    issue(i_type(rnd_imm12(), rnd_reg(), 3'd0, 5'd3, 7'b1111111));
    issue(i_type(12'h300, rnd_reg(), 3'd1, 5'd4, 7'b1110011));  // CSR
    issue(r_type(7'h01, rnd_reg(), rnd_reg(), 3'd0, 5'd7));     // mul
    issue(i_type(rnd_imm12(), rnd_reg(), 3'd3, 5'd9, decode_pkg::op_load));
    issue(i_type({7'h20, rnd_reg()}, rnd_reg(), 3'd1, 5'd5, decode_pkg::op_op_imm));
    issue(i_type(rnd_imm12(), rnd_reg(), 3'd1, 5'd6, decode_pkg::op_jalr));
    issue(i_type(12'h0ff, 5'd0, 3'd0, 5'd0, decode_pkg::op_misc_mem));  // fence
    end_test();

    $display("Done: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_decode_top

// ==== tb_clock.sv ====
// ################################################
// Free running clock, reset low for 4 cycles
// ################################################

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int Period      = 40;
  localparam int ResetCycles = 4;

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);  // Release away from the edge
    rst_n = 1'b1;
  end

endmodule : tb_clock

// ==== decode_top.sv ====
// ################################################
// Decode front, fetch strobe to exec_valid 2 cycles
// ################################################

module decode_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   fetch_valid,
  input  decode_pkg::fetch_pkt_t fetch,
  input  logic                   cfg_wr,
  input  decode_pkg::pred_mode_t cfg_wdata,
  output decode_pkg::pred_mode_t cfg_rdata,
  output logic                   exec_valid,
  output decode_pkg::exec_pkt_t  exec
);

  decode_pkg::pred_mode_t pred_mode;
  decode_pkg::d1_pkt_t    d1;
  logic                   d1_valid;

  decode_cfg i_decode_cfg (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_wr   (cfg_wr),
    .cfg_wdata(cfg_wdata),
    .pred_mode(pred_mode),
    .cfg_rdata(cfg_rdata)
  );

  id0 i_id0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .fetch_valid(fetch_valid),
    .fetch      (fetch),
    .pred_mode  (pred_mode),
    .d1_valid   (d1_valid),
    .d1         (d1)
  );

  id1 i_id1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .d1_valid  (d1_valid),
    .d1        (d1),
    .exec_valid(exec_valid),
    .exec      (exec)
  );

endmodule : decode_top

// ==== id1.sv ====
// ################################################
// Decode stage register toward execute, one cycle
// Control bits are zero when no instruction is valid
// ################################################

module id1 (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  d1_valid,
  input  decode_pkg::d1_pkt_t   d1,
  output logic                  exec_valid,
  output decode_pkg::exec_pkt_t exec
);

  decode_pkg::exec_pkt_t exec_d;
  decode_pkg::imm_t      imm_next;
  decode_pkg::alu_op_t   alu_op_next;
  decode_pkg::lsu_op_t   lsu_op_next;
  decode_pkg::br_op_t    br_op_next;
  logic                  rd_en_next;
  logic                  use_imm_next;
  logic                  use_pc_next;
  logic                  alu_next;
  logic                  lsu_next;
  logic                  illegal_next;

  id1_ctrl_imm i_id1_ctrl_imm (
    .instr     (d1.instr),
    .compressed(d1.comp),
    .imm       (imm_next),
    .rd_en     (rd_en_next),
    .use_imm   (use_imm_next),
    .use_pc    (use_pc_next),
    .alu       (alu_next),
    .lsu       (lsu_next),
    .illegal   (illegal_next),
    .alu_op    (alu_op_next),
    .lsu_op    (lsu_op_next),
    .br_op     (br_op_next)
  );

  always_comb begin
    exec_d.pc        = d1.pc;
    exec_d.comp      = d1.comp;
    exec_d.br        = d1.br && d1_valid;
    exec_d.br_ataken = d1.br_ataken;
    exec_d.use_imm   = use_imm_next;
    exec_d.use_pc    = use_pc_next;
    exec_d.imm       = imm_next;
    exec_d.illegal   = illegal_next && d1_valid;
    exec_d.alu       = alu_next && d1_valid;
    exec_d.alu_op    = alu_op_next;
    exec_d.rd_addr   = d1.rd_addr;
    exec_d.lsu       = lsu_next && d1_valid;
    exec_d.lsu_op    = lsu_op_next;
    exec_d.br_op     = br_op_next;
    exec_d.rd_en     = rd_en_next && d1_valid;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exec_valid <= 1'b0;
      exec       <= '0;
    end else begin
      exec_valid <= d1_valid && !flush;
      exec       <= exec_d;
    end
  end

endmodule : id1

// ==== id1_ctrl_imm.sv ====
// ################################################
// RV32I control and immediate decode, no M/A/CSR
// Fence is a no-op, compressed is always illegal
// ################################################

module id1_ctrl_imm (
  input  decode_pkg::instr_t  instr,
  input  logic                compressed,
  output decode_pkg::imm_t    imm,
  output logic                rd_en,
  output logic                use_imm,
  output logic                use_pc,
  output logic                alu,
  output logic                lsu,
  output logic                illegal,
  output decode_pkg::alu_op_t alu_op,
  output decode_pkg::lsu_op_t lsu_op,
  output decode_pkg::br_op_t  br_op
);

  decode_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  decode_pkg::imm_t    imm_i;
  decode_pkg::imm_t    imm_s;
  decode_pkg::imm_t    imm_b;
  decode_pkg::imm_t    imm_u;
  decode_pkg::imm_t    imm_j;
  decode_pkg::alu_op_t arith_op;
  logic                legal;
  logic                writes_rd;
  logic                alu_raw;
  logic                lsu_raw;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 to ALU op, bit 30 picks sub/sra
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (instr[30] && opcode == decode_pkg::op_op) ?
                          decode_pkg::alu_sub : decode_pkg::alu_add;
      3'b001:  arith_op = decode_pkg::alu_sll;
      3'b010:  arith_op = decode_pkg::alu_slt;
      3'b011:  arith_op = decode_pkg::alu_sltu;
      3'b100:  arith_op = decode_pkg::alu_xor;
      3'b101:  arith_op = instr[30] ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'b110:  arith_op = decode_pkg::alu_or;
      default: arith_op = decode_pkg::alu_and;
    endcase
  end

  always_comb begin
    imm       = '0;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    alu_raw   = 1'b0;
    lsu_raw   = 1'b0;
    writes_rd = 1'b0;
    legal     = 1'b0;
    alu_op    = decode_pkg::alu_add;
    lsu_op    = '0;
    br_op     = decode_pkg::br_eq;
    case (opcode)
      decode_pkg::op_lui: begin
        legal     = 1'b1;
        alu_raw   = 1'b1;
        use_imm   = 1'b1;
        imm       = imm_u;
        alu_op    = decode_pkg::alu_pass_b;
        writes_rd = 1'b1;
      end
      decode_pkg::op_auipc: begin
        legal     = 1'b1;
        alu_raw   = 1'b1;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        imm       = imm_u;
        writes_rd = 1'b1;
      end
      decode_pkg::op_jal: begin
        legal     = 1'b1;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        imm       = imm_j;
        br_op     = decode_pkg::br_jump;
        writes_rd = 1'b1;  // Link
      end
      decode_pkg::op_jalr: begin
        legal     = (funct3 == 3'b000);
        use_imm   = 1'b1;
        imm       = imm_i;
        br_op     = decode_pkg::br_jump;
        writes_rd = 1'b1;
      end
      decode_pkg::op_branch: begin
        legal   = (funct3 != 3'b010) && (funct3 != 3'b011);
        use_imm = 1'b1;
        use_pc  = 1'b1;
        imm     = imm_b;
        br_op   = funct3;
      end
      decode_pkg::op_load: begin
        legal     = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
        lsu_raw   = 1'b1;
        use_imm   = 1'b1;
        imm       = imm_i;
        lsu_op    = funct3;
        writes_rd = 1'b1;
      end
      decode_pkg::op_store: begin
        legal   = (funct3[2] == 1'b0) && (funct3 != 3'b011);
        lsu_raw = 1'b1;
        use_imm = 1'b1;
        imm     = imm_s;
        lsu_op  = funct3;
      end
      decode_pkg::op_op_imm: begin
        // Only shifts carry funct7
        case (funct3)
          3'b001:  legal = (funct7 == 7'b0000000);
          3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: legal = 1'b1;
        endcase
        alu_raw   = 1'b1;
        use_imm   = 1'b1;
        imm       = imm_i;
        alu_op    = arith_op;
        writes_rd = 1'b1;
      end
      decode_pkg::op_op: begin
        legal     = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        alu_raw   = 1'b1;
        alu_op    = arith_op;
        writes_rd = 1'b1;
      end
      decode_pkg::op_misc_mem: begin
        legal = (funct3 == 3'b000);  // Fence only
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  assign illegal = !legal || compressed;
  assign rd_en   = writes_rd && (instr[11:7] != 5'd0) && !illegal;
  assign alu     = alu_raw && !illegal;
  assign lsu     = lsu_raw && !illegal;

endmodule : id1_ctrl_imm

// ==== id0.sv ====
// ################################################
// Predecode, one cycle. No back-pressure, a strobe
// that meets a flush is dropped
// ################################################

module id0 (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   fetch_valid,
  input  decode_pkg::fetch_pkt_t fetch,
  input  decode_pkg::pred_mode_t pred_mode,
  output logic                   d1_valid,
  output decode_pkg::d1_pkt_t    d1
);

  decode_pkg::opcode_t opcode;
  decode_pkg::d1_pkt_t d1_d;
  logic                is_branch;
  logic                is_jump;
  logic                b_taken;

  assign opcode    = fetch.instr[6:0];
  assign is_branch = (opcode == decode_pkg::op_branch);
  assign is_jump   = (opcode == decode_pkg::op_jal) || (opcode == decode_pkg::op_jalr);

  // Static guess for conditional branches
  always_comb begin
    case (pred_mode)
      decode_pkg::pred_always:   b_taken = 1'b1;
      decode_pkg::pred_backward: b_taken = fetch.instr[31];  // Offset sign
      default:                   b_taken = 1'b0;
    endcase
  end

  always_comb begin
    d1_d.instr     = fetch.instr;
    d1_d.pc        = fetch.pc;
    d1_d.rd_addr   = fetch.instr[11:7];
    d1_d.comp      = (fetch.instr[1:0] != 2'b11);
    d1_d.br        = is_branch || is_jump;
    d1_d.br_ataken = is_jump || (is_branch && b_taken);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d1_valid <= 1'b0;
      d1       <= '0;
    end else begin
      d1_valid <= fetch_valid && !flush;
      if (fetch_valid) begin
        d1 <= d1_d;
      end
    end
  end

endmodule : id0

// ==== decode_cfg.sv ====
// ################################################
// Prediction mode register, resets to backward taken
// Write lands one cycle after the strobe
// ################################################

module decode_cfg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_wr,
  input  decode_pkg::pred_mode_t cfg_wdata,
  output decode_pkg::pred_mode_t pred_mode,
  output decode_pkg::pred_mode_t cfg_rdata
);

  decode_pkg::pred_mode_t mode_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_q <= decode_pkg::pred_backward;
    end else if (cfg_wr) begin
      mode_q <= cfg_wdata;
    end
  end

  assign pred_mode = mode_q;  // To predecode
  assign cfg_rdata = mode_q;  // Software readback

endmodule : decode_cfg

// ==== decode_pkg.sv ====
// ################################################
// RV32I decode front shared types. PC is halfword
// aligned (bit 0 dropped), compressed is not expanded
// ################################################

package decode_pkg;

  localparam int AluOpWidth    = 4;
  localparam int LsuOpWidth    = 3;
  localparam int BranchOpWidth = 3;

  typedef logic [31:0]              instr_t;
  typedef logic [31:1]              pc_t;
  typedef logic [4:0]               reg_addr_t;
  typedef logic [31:0]              imm_t;
  typedef logic [6:0]               opcode_t;
  typedef logic [AluOpWidth-1:0]    alu_op_t;
  typedef logic [LsuOpWidth-1:0]    lsu_op_t;
  typedef logic [BranchOpWidth-1:0] br_op_t;

  // Major opcodes
  localparam opcode_t op_lui      = 7'b0110111;
  localparam opcode_t op_auipc    = 7'b0010111;
  localparam opcode_t op_jal      = 7'b1101111;
  localparam opcode_t op_jalr     = 7'b1100111;
  localparam opcode_t op_branch   = 7'b1100011;
  localparam opcode_t op_load     = 7'b0000011;
  localparam opcode_t op_store    = 7'b0100011;
  localparam opcode_t op_op_imm   = 7'b0010011;
  localparam opcode_t op_op       = 7'b0110011;
  localparam opcode_t op_misc_mem = 7'b0001111;

  localparam alu_op_t alu_add    = 4'd0;
  localparam alu_op_t alu_sub    = 4'd1;
  localparam alu_op_t alu_sll    = 4'd2;
  localparam alu_op_t alu_slt    = 4'd3;
  localparam alu_op_t alu_sltu   = 4'd4;
  localparam alu_op_t alu_xor    = 4'd5;
  localparam alu_op_t alu_srl    = 4'd6;
  localparam alu_op_t alu_sra    = 4'd7;
  localparam alu_op_t alu_or     = 4'd8;
  localparam alu_op_t alu_and    = 4'd9;
  localparam alu_op_t alu_pass_b = 4'd10; // lui

  // Access funct3 as is
  localparam lsu_op_t lsu_b  = 3'b000;
  localparam lsu_op_t lsu_h  = 3'b001;
  localparam lsu_op_t lsu_w  = 3'b010;
  localparam lsu_op_t lsu_bu = 3'b100;
  localparam lsu_op_t lsu_hu = 3'b101;

  // Branch funct3, jump takes an unused code
  localparam br_op_t br_eq   = 3'b000;
  localparam br_op_t br_ne   = 3'b001;
  localparam br_op_t br_jump = 3'b010;
  localparam br_op_t br_lt   = 3'b100;
  localparam br_op_t br_ge   = 3'b101;
  localparam br_op_t br_ltu  = 3'b110;
  localparam br_op_t br_geu  = 3'b111;

  typedef enum logic [1:0] {
    pred_never    = 2'd0,
    pred_backward = 2'd1,
    pred_always   = 2'd2
  } pred_mode_t;

  typedef struct packed {
    instr_t instr;
    pc_t    pc;
  } fetch_pkt_t;

  typedef struct packed {
    instr_t    instr;
    pc_t       pc;
    reg_addr_t rd_addr;
    logic      comp;
    logic      br;
    logic      br_ataken;
  } d1_pkt_t;

  typedef struct packed {
    pc_t       pc;
    logic      comp;
    logic      br;
    logic      br_ataken;
    logic      use_imm;
    logic      use_pc;
    imm_t      imm;
    logic      illegal;
    logic      alu;
    alu_op_t   alu_op;
    reg_addr_t rd_addr;
    logic      lsu;
    lsu_op_t   lsu_op;
    br_op_t    br_op;
    logic      rd_en;
  } exec_pkt_t;

endpackage : decode_pkg
